/* hdl/afc_pkg.sv */
// AFC controller shared widths, sequencer states and bundled signal types
`default_nettype none

package afc_pkg;

    // --------------------
    // widths and constants
    // --------------------
    localparam int BAND_W = 7;
    localparam int NCNT_W = 14;
    localparam int DIVR_W = 16;
    localparam int CNTT_W = 7;

    // search starts from the middle of the cap bank
    localparam logic [BAND_W-1:0] BAND_MID     = {1'b1, {(BAND_W-1){1'b0}}};
    localparam logic [NCNT_W-1:0] ERR_MAX      = '1;
    localparam logic [NCNT_W-1:0] FORCE_MINERR = 14'h1555;

    // --------------------
    // types
    // --------------------
    typedef enum logic [3:0] {
        idle,
        band_init,
        wait_vco_stable,
        cntr_reset,
        cntr_en_pre,
        cntr_en,
        cntr_en_post,
        cntr_datasyn,
        band_update,
        set_band_opt,
        wait_settle,
        cal_end
    } afc_state_e;

    // static register settings
    typedef struct packed {
        logic [DIVR_W-1:0] divr;
        logic [CNTT_W-1:0] cnt_time;
        logic [1:0]        vcostable_time;
        logic [BAND_W-1:0] force_band;
    } afc_cfg_t;

    // strobes to the external frequency counter
    typedef struct packed {
        logic cntr_rstn;
        logic cntr_en;
        logic cntr_datasyn;
    } afc_cntr_t;

    // sequencer to band search
    typedef struct packed {
        logic       init;
        logic       update;
        logic       set_opt;
        logic       done;
        logic [2:0] loop_idx;
    } afc_step_t;

endpackage

`default_nettype wire

/* hdl/afc_ctrl_sync.sv */
// AFC control synchronizer: enable and forced-band sync, delayed start pulse
`timescale 1ns/1ps
`default_nettype none

module afc_ctrl_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  wire  clk_gated,
    input  wire  rstn,
    input  wire  afc_en,
    input  wire  rg_forceband_en,
    output logic cal_start,
    output logic force_en
);

    // bit 0 carries afc_en, bit 1 carries rg_forceband_en
    logic [SYNC_STAGES-1:0][1:0] sync_q;
    logic                        en_sync;
    logic                        en_sync_d1;
    logic                        rise_q;
    logic                        rise_d1;
    logic                        rise_d2;

    assign en_sync  = sync_q[SYNC_STAGES-1][0];
    assign force_en = sync_q[SYNC_STAGES-1][1];

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            sync_q     <= '0;
            en_sync_d1 <= 1'b0;
            rise_q     <= 1'b0;
            rise_d1    <= 1'b0;
            rise_d2    <= 1'b0;
        end else begin
            sync_q[0] <= {rg_forceband_en, afc_en};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            en_sync_d1 <= en_sync;
            // registered rising edge of the synced enable
            rise_q     <= en_sync & ~en_sync_d1;
            // two more cycles so the config inputs have settled
            rise_d1    <= rise_q;
            rise_d2    <= rise_d1;
        end
    end

    // forced band suppresses any start
    assign cal_start = rise_d2 & ~force_en;

endmodule

`default_nettype wire

/* hdl/afc_ntarget_calc.sv */
// AFC target count: serial shift-add of divider ratio times window length, rounded
`timescale 1ns/1ps
`default_nettype none

module afc_ntarget_calc (
    input  wire                       clk_gated,
    input  wire                       rstn,
    input  wire                       init,
    input  wire [afc_pkg::DIVR_W-1:0] divr,
    input  wire [afc_pkg::CNTT_W-1:0] cnt_time,
    output logic [afc_pkg::NCNT_W-1:0] ntarget
);

    import afc_pkg::*;

    localparam int ACC_W   = DIVR_W + CNTT_W;
    localparam int TOP_BIT = ACC_W - 2;

    logic [CNTT_W:0]   win_len;
    logic [ACC_W-1:0]  divr_ext;
    logic [ACC_W-1:0]  addend;
    logic [ACC_W-1:0]  acc;
    logic [ACC_W-1:0]  acc_sum;
    logic [2:0]        bit_idx;
    logic [2:0]        sel;
    logic              busy;
    logic [NCNT_W-1:0] rounded;

    // window is cnt_time+1 cycles long
    assign win_len  = {1'b0, cnt_time} + 1'b1;
    assign divr_ext = ACC_W'(divr);

    // init cycle already handles bit 0
    assign sel     = init ? 3'd0 : bit_idx;
    assign addend  = win_len[sel] ? (divr_ext << sel) : '0;
    assign acc_sum = (init ? '0 : acc) + addend;
    assign rounded = acc_sum[TOP_BIT -: NCNT_W] + NCNT_W'(acc_sum[TOP_BIT-NCNT_W]);

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            busy    <= 1'b0;
            bit_idx <= '0;
            ntarget <= '0;
        end else if (init) begin
            busy    <= 1'b1;
            bit_idx <= 3'd1;
        end else if (busy) begin
            if (bit_idx == 3'd7) begin
                busy    <= 1'b0;
                ntarget <= rounded;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    // partial sum
    always_ff @(posedge clk_gated) begin
        if (init || busy) begin
            acc <= acc_sum;
        end
    end

endmodule

`default_nettype wire

/* hdl/afc_seq_fsm.sv */
// AFC sequencer: per-step timing, loop index and frequency counter strobes
`timescale 1ns/1ps
`default_nettype none

module afc_seq_fsm (
    input  wire                       clk_gated,
    input  wire                       rstn,
    input  wire                       cal_start,
    input  wire [1:0]                 vcostable_time,
    input  wire [afc_pkg::CNTT_W-1:0] cnt_time,
    output afc_pkg::afc_step_t        step,
    output afc_pkg::afc_cntr_t        cntr,
    output logic                      afc_openloop_en
);

    import afc_pkg::*;

    afc_state_e        state;
    afc_state_e        state_next;
    logic [CNTT_W-1:0] timer;
    logic [3:0]        stable_last;
    logic              stable_end;
    logic              window_end;
    logic              timed;
    logic [2:0]        loop_idx;
    logic              loop_last;

    // --------------------
    // timer compares
    // --------------------
    // 2, 4, 8 or 16 cycles of settling
    always_comb begin
        case (vcostable_time)
            2'd0:    stable_last = 4'd1;
            2'd1:    stable_last = 4'd3;
            2'd2:    stable_last = 4'd7;
            default: stable_last = 4'd15;
        endcase
    end

    assign stable_end = (timer == CNTT_W'(stable_last));
    assign window_end = (timer == cnt_time);
    assign loop_last  = (loop_idx == 3'd6);
    assign timed      = (state inside {wait_vco_stable, cntr_en, wait_settle});

    // --------------------
    // state machine
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            idle:            if (cal_start) state_next = band_init;
            band_init:       state_next = wait_vco_stable;
            wait_vco_stable: if (stable_end) state_next = cntr_reset;
            cntr_reset:      state_next = cntr_en_pre;
            cntr_en_pre:     state_next = cntr_en;
            cntr_en:         if (window_end) state_next = cntr_en_post;
            cntr_en_post:    state_next = cntr_datasyn;
            cntr_datasyn:    state_next = band_update;
            band_update:     state_next = loop_last ? set_band_opt : band_init;
            set_band_opt:    state_next = wait_settle;
            wait_settle:     if (stable_end) state_next = cal_end;
            cal_end:         state_next = idle;
            default:         state_next = idle;
        endcase
    end

    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            state    <= idle;
            timer    <= '0;
            loop_idx <= '0;
        end else begin
            state <= state_next;
            // one timer shared by all timed states, restarted on any transition
            if (state_next != state) begin
                timer <= '0;
            end else if (timed) begin
                timer <= timer + 1'b1;
            end
            if (state == idle && cal_start) begin
                loop_idx <= '0;
            end else if (state == band_update) begin
                loop_idx <= loop_idx + 1'b1;
            end
        end
    end

    // --------------------
    // counter strobes
    // --------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            cntr.cntr_rstn    <= 1'b1;
            cntr.cntr_en      <= 1'b0;
            cntr.cntr_datasyn <= 1'b0;
        end else begin
            // low for the cntr_reset cycle only
            cntr.cntr_rstn <= !(state == wait_vco_stable && stable_end);
            if (state == cntr_en_pre) begin
                cntr.cntr_en <= 1'b1;
            end else if (state == cntr_en && window_end) begin
                cntr.cntr_en <= 1'b0;
            end
            cntr.cntr_datasyn <= (state == cntr_en_post);
        end
    end

    // step controls to the band search
    assign step.init     = (state == band_init) && (loop_idx == '0);
    assign step.update   = (state == band_update);
    assign step.set_opt  = (state == set_band_opt);
    assign step.done     = (state == cal_end);
    assign step.loop_idx = loop_idx;

    assign afc_openloop_en = (state != idle);

endmodule

`default_nettype wire

/* hdl/afc_band_search.sv */
// AFC band search: count error, binary band update, best-band tracking, results
`timescale 1ns/1ps
`default_nettype none

module afc_band_search (
    input  wire                        clk_gated,
    input  wire                        rstn,
    input  afc_pkg::afc_step_t         step,
    input  wire                        force_en,
    input  wire [afc_pkg::BAND_W-1:0]  force_band,
    input  wire [afc_pkg::NCNT_W-1:0]  ntarget,
    input  wire [afc_pkg::NCNT_W-1:0]  a2d_afc_ncntr,
    output logic [afc_pkg::BAND_W-1:0] afc_vco_capband,
    output logic [afc_pkg::NCNT_W-1:0] afc_minerr,
    output logic                       afc_finish
);

    import afc_pkg::*;

    logic [NCNT_W:0]   err_diff;
    logic              err_neg;
    logic [NCNT_W-1:0] err_abs;
    logic [NCNT_W-1:0] err_min;
    logic              err_better;
    logic [BAND_W-1:0] band_opt;
    logic [BAND_W-1:0] band_step;
    logic [2:0]        bit_pos;

    // --------------------
    // error
    // --------------------
    assign err_diff = {1'b0, a2d_afc_ncntr} - {1'b0, ntarget};
    assign err_neg  = err_diff[NCNT_W];

    // saturate the one magnitude that does not fit
    always_comb begin
        if (!err_neg) begin
            err_abs = err_diff[NCNT_W-1:0];
        end else if (err_diff[NCNT_W-1:0] == '0) begin
            err_abs = ERR_MAX;
        end else begin
            err_abs = ~err_diff[NCNT_W-1:0] + 1'b1;
        end
    end

    // strict compare, first band wins a tie
    assign err_better = (err_abs < err_min);

    // --------------------
    // binary step
    // --------------------
    assign bit_pos = 3'(BAND_W - 1) - step.loop_idx;

    // count too low means band too high, drop the bit under test
    always_comb begin
        band_step = afc_vco_capband;
        if (err_neg) begin
            band_step[bit_pos] = 1'b0;
        end
        if (bit_pos != '0) begin
            band_step[bit_pos - 1'b1] = 1'b1;
        end
    end

    // --------------------
    // band and minimum
    // --------------------
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_vco_capband <= BAND_MID;
            band_opt        <= BAND_MID;
            err_min         <= ERR_MAX;
        end else if (force_en) begin
            afc_vco_capband <= force_band;
        end else if (step.init) begin
            afc_vco_capband <= BAND_MID;
            band_opt        <= BAND_MID;
            err_min         <= ERR_MAX;
        end else if (step.update) begin
            afc_vco_capband <= band_step;
            if (err_better) begin
                err_min  <= err_abs;
                band_opt <= afc_vco_capband;
            end
        end else if (step.set_opt) begin
            afc_vco_capband <= band_opt;
        end
    end

    // published results
    always_ff @(posedge clk_gated or negedge rstn) begin
        if (!rstn) begin
            afc_minerr <= '0;
            afc_finish <= 1'b0;
        end else if (force_en) begin
            afc_minerr <= FORCE_MINERR;
            afc_finish <= 1'b0;
        end else if (step.init) begin
            afc_finish <= 1'b0;
        end else if (step.done) begin
            afc_minerr <= err_min;
            afc_finish <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/afc_top.sv */
// AFC controller top: sync, sequencer, target calculator and band search
`timescale 1ns/1ps
`default_nettype none

module afc_top #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                        clk_gated,
    input  wire                        rstn,
    input  wire                        afc_en,
    input  wire                        rg_forceband_en,
    input  afc_pkg::afc_cfg_t          cfg,
    input  wire [afc_pkg::NCNT_W-1:0]  a2d_afc_ncntr,
    output afc_pkg::afc_cntr_t         cntr,
    output logic                       afc_openloop_en,
    output logic [afc_pkg::BAND_W-1:0] afc_vco_capband,
    output logic [afc_pkg::NCNT_W-1:0] afc_minerr,
    output logic                       afc_finish
);

    import afc_pkg::*;

    logic              cal_start;
    logic              force_en;
    afc_step_t         step;
    logic [NCNT_W-1:0] ntarget;

    // decode
    afc_ctrl_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_ctrl_sync (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .afc_en          (afc_en),
        .rg_forceband_en (rg_forceband_en),
        .cal_start       (cal_start),
        .force_en        (force_en)
    );

    // execute
    afc_seq_fsm u_seq_fsm (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .cal_start       (cal_start),
        .vcostable_time  (cfg.vcostable_time),
        .cnt_time        (cfg.cnt_time),
        .step            (step),
        .cntr            (cntr),
        .afc_openloop_en (afc_openloop_en)
    );

    afc_ntarget_calc u_ntarget_calc (
        .clk_gated (clk_gated),
        .rstn      (rstn),
        .init      (step.init),
        .divr      (cfg.divr),
        .cnt_time  (cfg.cnt_time),
        .ntarget   (ntarget)
    );

    // result
    afc_band_search u_band_search (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .step            (step),
        .force_en        (force_en),
        .force_band      (cfg.force_band),
        .ntarget         (ntarget),
        .a2d_afc_ncntr   (a2d_afc_ncntr),
        .afc_vco_capband (afc_vco_capband),
        .afc_minerr      (afc_minerr),
        .afc_finish      (afc_finish)
    );

endmodule

`default_nettype wire

/* test/afc_checker.sv */
// AFC checker: replays each calibration from the VCO model and compares DUT outputs
`timescale 1ns/1ps
`default_nettype none

module afc_checker #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                       clk_gated,
    input  wire                       rstn,
    input  wire                       rg_forceband_en,
    input  afc_pkg::afc_cfg_t         cfg,
    input  wire [afc_pkg::NCNT_W-1:0] vco_offset,
    input  wire [6:0]                 vco_slope,
    input  afc_pkg::afc_cntr_t        cntr,
    input  wire                       afc_openloop_en,
    input  wire [afc_pkg::BAND_W-1:0] afc_vco_capband,
    input  wire [afc_pkg::NCNT_W-1:0] afc_minerr,
    input  wire                       afc_finish,
    output int                        err_count,
    output int                        check_count,
    output int                        run_count
);

    import afc_pkg::*;

    int                errs      = 0;
    int                checks    = 0;
    int                runs      = 0;
    logic              open_d    = 1'b0;
    logic              fin_d     = 1'b0;
    logic              en_d      = 1'b0;
    logic              dsyn_d    = 1'b0;
    logic              crst_d    = 1'b1;
    bit                run_seen  = 1'b0;
    // 0 wait reset strobe, 1 wait enable, 2 counting, 3 wait data sync
    int                phase;
    int                steps;
    int                en_len;
    int                force_cnt;
    logic [BAND_W-1:0] band_seq [7];
    logic [BAND_W-1:0] exp_band;
    logic [NCNT_W-1:0] exp_err;

    assign err_count   = errs;
    assign check_count = checks;
    assign run_count   = runs;

    task automatic check_value(input bit ok, input string msg);
        checks++;
        if (!ok) begin
            errs++;
            $display("ERR %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_failure(input string msg);
        errs++;
        $display("%s", msg);
    endtask

    // --------------------
    // reference model
    // --------------------
    // window product, bits 21 to 8, rounded up on bit 7
    function automatic logic [NCNT_W-1:0] target_count(input logic [DIVR_W-1:0] divr,
                                                       input logic [CNTT_W-1:0] ct);
        logic [22:0] prod;
        prod = 23'(divr) * (23'(ct) + 23'd1);
        return prod[21:8] + NCNT_W'(prod[7]);
    endfunction

    function automatic int vco_count(input logic [BAND_W-1:0] band);
        return int'(vco_offset) + int'(vco_slope) * int'(band);
    endfunction

    task automatic predict_run();
        logic [BAND_W-1:0] band;
        int                target;
        int                diff;
        int                mag;
        int                pos;
        target   = int'(target_count(cfg.divr, cfg.cnt_time));
        band     = BAND_MID;
        exp_band = BAND_MID;
        exp_err  = ERR_MAX;
        for (int i = 0; i < 7; i++) begin
            band_seq[i] = band;
            diff = (vco_count(band) % 16384) - target;
            mag  = (diff < 0) ? -diff : diff;
            if (mag > int'(ERR_MAX)) begin
                mag = int'(ERR_MAX);
            end
            if (mag < int'(exp_err)) begin
                exp_err  = NCNT_W'(mag);
                exp_band = band;
            end
            pos = BAND_W - 1 - i;
            if (diff < 0) begin
                band[pos] = 1'b0;
            end
            if (pos > 0) begin
                band[pos-1] = 1'b1;
            end
        end
    endtask

    // --------------------
    // monitor
    // --------------------
    always @(negedge clk_gated) begin
        if (!rstn) begin
            check_value(cntr.cntr_rstn && !cntr.cntr_en && !cntr.cntr_datasyn,
                        "counter strobes active in reset");
            check_value(!afc_openloop_en && !afc_finish, "openloop or finish high in reset");
            check_value(afc_vco_capband == BAND_MID,
                        $sformatf("capband %0d in reset, expected %0d", afc_vco_capband, BAND_MID));
            check_value(afc_minerr == '0, $sformatf("minerr %0h in reset", afc_minerr));
            force_cnt = 0;
            run_seen  = 1'b0;
        end else begin
            // forced band, once the synchronizer has passed it through
            force_cnt = rg_forceband_en ? force_cnt + 1 : 0;
            if (force_cnt >= SYNC_STAGES + 2) begin
                check_value(afc_vco_capband == cfg.force_band,
                            $sformatf("forced capband %0d, expected %0d",
                                      afc_vco_capband, cfg.force_band));
                check_value(afc_minerr == FORCE_MINERR,
                            $sformatf("forced minerr %0h, expected %0h", afc_minerr, FORCE_MINERR));
                check_value(!afc_finish, "afc_finish high in forced mode");
                check_value(!afc_openloop_en, "calibration started in forced mode");
            end

            if (afc_openloop_en && !open_d) begin
                predict_run();
                phase    = 0;
                steps    = 0;
                run_seen = 1'b1;
            end

            if (afc_openloop_en) begin
                if (open_d) begin
                    check_value(!afc_finish, "afc_finish not cleared at run start");
                end
                if (!cntr.cntr_rstn) begin
                    if (phase != 0 || !crst_d) begin
                        report_failure("counter reset strobe out of order or too long");
                    end
                    phase = 1;
                end
                if (cntr.cntr_en) begin
                    if (!en_d) begin
                        if (phase != 1) begin
                            report_failure("counter enable rose without a counter reset");
                        end
                        phase  = 2;
                        en_len = 0;
                    end
                    en_len++;
                end else if (en_d) begin
                    check_value(en_len == int'(cfg.cnt_time) + 1,
                                $sformatf("cntr_en high %0d cycles, expected %0d",
                                          en_len, int'(cfg.cnt_time) + 1));
                    phase = 3;
                end
                if (cntr.cntr_datasyn) begin
                    if (phase != 3 || dsyn_d) begin
                        report_failure("data sync strobe out of order or longer than a cycle");
                    end else if (steps < 7) begin
                        check_value(afc_vco_capband == band_seq[steps],
                                    $sformatf("step %0d band %0d, expected %0d",
                                              steps, afc_vco_capband, band_seq[steps]));
                    end
                    steps++;
                    phase = 0;
                end
            end else begin
                if (open_d) begin
                    if (steps != 7 || phase != 0) begin
                        report_failure($sformatf("run ended after %0d counter cycles, not 7",
                                                 steps));
                    end
                    runs++;
                end
                check_value(cntr.cntr_rstn && !cntr.cntr_en && !cntr.cntr_datasyn,
                            "counter strobes active outside a run");
            end

            if (afc_finish && !fin_d) begin
                if (!run_seen) begin
                    report_failure("afc_finish rose without a calibration run");
                end else begin
                    check_value(afc_vco_capband == exp_band,
                                $sformatf("final band %0d, expected %0d",
                                          afc_vco_capband, exp_band));
                    check_value(afc_minerr == exp_err,
                                $sformatf("minerr %0d, expected %0d", afc_minerr, exp_err));
                end
            end
        end
        open_d = afc_openloop_en;
        fin_d  = afc_finish;
        en_d   = cntr.cntr_en;
        dsyn_d = cntr.cntr_datasyn;
        crst_d = cntr.cntr_rstn;
    end

endmodule

`default_nettype wire

/* test/afc_tb.sv */
// AFC testbench with clock, reset, random calibration runs, forced band and VCO count model
`timescale 1ns/1ps
`default_nettype none

module afc_tb;

    import afc_pkg::*;

    localparam int SYNC_STAGES    = 2;
    localparam int NUM_RUNS       = 6;
    // worst step has 16 settle cycles and a 128-cycle window
    localparam int RUN_MAX_CYCLES = 7 * (6 + 16 + 128) + 40;
    localparam int START_LIMIT    = SYNC_STAGES + 10;
    localparam int WATCHDOG_NS    = ((NUM_RUNS + 1) * (RUN_MAX_CYCLES + 30) + 300) * 10;

    logic              clk_gated     = 1'b0;
    logic              rstn;
    logic              afc_en;
    logic              rg_forceband_en;
    afc_cfg_t          cfg;
    logic [NCNT_W-1:0] a2d_afc_ncntr = '0;
    afc_cntr_t         cntr;
    logic              afc_openloop_en;
    logic [BAND_W-1:0] afc_vco_capband;
    logic [NCNT_W-1:0] afc_minerr;
    logic              afc_finish;

    logic [NCNT_W-1:0] vco_offset;
    logic [6:0]        vco_slope;
    logic [31:0]       lfsr;
    int                err_count;
    int                check_count;
    int                run_count;
    int                tb_errs    = 0;
    int                tests_done = 0;

    always #5 clk_gated = ~clk_gated;

    // VCO model count follows the applied band
    always @(negedge clk_gated) begin
        a2d_afc_ncntr <= vco_offset + vco_slope * afc_vco_capband;
    end

    afc_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut0 (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .afc_en          (afc_en),
        .rg_forceband_en (rg_forceband_en),
        .cfg             (cfg),
        .a2d_afc_ncntr   (a2d_afc_ncntr),
        .cntr            (cntr),
        .afc_openloop_en (afc_openloop_en),
        .afc_vco_capband (afc_vco_capband),
        .afc_minerr      (afc_minerr),
        .afc_finish      (afc_finish)
    );

    afc_checker #(
        .SYNC_STAGES (SYNC_STAGES)
    ) checker0 (
        .clk_gated       (clk_gated),
        .rstn            (rstn),
        .rg_forceband_en (rg_forceband_en),
        .cfg             (cfg),
        .vco_offset      (vco_offset),
        .vco_slope       (vco_slope),
        .cntr            (cntr),
        .afc_openloop_en (afc_openloop_en),
        .afc_vco_capband (afc_vco_capband),
        .afc_minerr      (afc_minerr),
        .afc_finish      (afc_finish),
        .err_count       (err_count),
        .check_count     (check_count),
        .run_count       (run_count)
    );

    // --------------------
    // random numbers
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_run_config();
        logic [31:0] r;
        draw_bits(16, r);
        cfg.divr <= r[15:0];
        draw_bits(6, r);
        cfg.cnt_time <= CNTT_W'(r[5:0]);
        draw_bits(2, r);
        cfg.vcostable_time <= r[1:0];
        draw_bits(13, r);
        vco_offset <= NCNT_W'(r[12:0]);
        draw_bits(6, r);
        vco_slope <= 7'(r[5:0]) + 7'd1;
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic finish_test(input string name, input int errs_before);
        int errs_now;
        errs_now = err_count + tb_errs;
        if (errs_now == errs_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s failed with %0d errors", name, errs_now - errs_before);
        end
        tests_done++;
    endtask

    task automatic run_calibration(input string name);
        int errs_before;
        int cycles;
        errs_before = err_count + tb_errs;
        @(negedge clk_gated);
        draw_run_config();
        repeat (4) @(negedge clk_gated);
        afc_en <= 1'b1;
        cycles = 0;
        while (!afc_openloop_en && cycles < START_LIMIT) begin
            @(negedge clk_gated);
            cycles++;
        end
        if (!afc_openloop_en) begin
            $display("%s: calibration did not start", name);
            tb_errs++;
        end else begin
            cycles = 0;
            // finish from the last run stays set until the new run has begun
            while (!(afc_finish && !afc_openloop_en) && cycles < RUN_MAX_CYCLES) begin
                @(negedge clk_gated);
                cycles++;
            end
            if (!afc_finish || afc_openloop_en) begin
                $display("%s: calibration did not finish in %0d cycles", name, RUN_MAX_CYCLES);
                tb_errs++;
            end
        end
        afc_en <= 1'b0;
        repeat (4) @(negedge clk_gated);
        @(posedge clk_gated);
        finish_test(name, errs_before);
    endtask

    task automatic forced_band_test();
        logic [31:0] r;
        int          errs_before;
        errs_before = err_count + tb_errs;
        @(negedge clk_gated);
        draw_bits(7, r);
        cfg.force_band  <= r[6:0];
        rg_forceband_en <= 1'b1;
        repeat (8) @(negedge clk_gated);
        afc_en <= 1'b1;
        repeat (12) @(negedge clk_gated);
        draw_bits(7, r);
        cfg.force_band <= r[6:0];
        repeat (8) @(negedge clk_gated);
        afc_en <= 1'b0;
        repeat (6) @(negedge clk_gated);
        rg_forceband_en <= 1'b0;
        repeat (10) @(negedge clk_gated);
        @(posedge clk_gated);
        finish_test("forced band", errs_before);
    endtask

    initial begin
        rstn            = 1'b0;
        afc_en          = 1'b0;
        rg_forceband_en = 1'b0;
        cfg             = '0;
        vco_offset      = '0;
        vco_slope       = 7'd1;
        lfsr            = 32'h67b1;
        repeat (10) @(negedge clk_gated);
        rstn <= 1'b1;
        repeat (3) @(negedge clk_gated);
        @(posedge clk_gated);
        finish_test("reset values", 0);
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_calibration($sformatf("random run %0d", r));
        end
        forced_band_test();
        run_calibration("run after force");
        if (run_count != NUM_RUNS + 1) begin
            $display("only %0d of %0d calibration runs completed", run_count, NUM_RUNS + 1);
            tb_errs++;
        end
        $display("tests %0d, runs %0d, checks %0d, errors %0d",
                 tests_done, run_count, check_count, err_count + tb_errs);
        if (err_count + tb_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/afc_pkg.sv
hdl/afc_ctrl_sync.sv
hdl/afc_ntarget_calc.sv
hdl/afc_seq_fsm.sv
hdl/afc_band_search.sv
hdl/afc_top.sv
test/afc_checker.sv
test/afc_tb.sv

/* Bender.yml */
package:
  name: afc_ctrl

sources:
  - hdl/afc_pkg.sv
  - hdl/afc_ctrl_sync.sv
  - hdl/afc_ntarget_calc.sv
  - hdl/afc_seq_fsm.sv
  - hdl/afc_band_search.sv
  - hdl/afc_top.sv
  - target: test
    files:
      - test/afc_checker.sv
      - test/afc_tb.sv
